// File: run_sim.sh
#!/usr/bin/env bash
# build the lce command testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 -f sim.f --top-module lce_cmd_tb -o lce_cmd_sim \
  && ./obj_dir/lce_cmd_sim +verilator+error+limit+100 > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation run failed"; exit 1; }

cat sim.log
grep -q "Test FAILED" sim.log && { echo "simulation failed"; exit 1; }
echo "simulation passed"
exit 0

// File: sim.f
source/lce_pkg.sv
source/lce_read_buf.sv
source/lce_cmd_fsm.sv
source/lce_cmd_top.sv
sim/lce_cmd_chk.sv
sim/lce_cmd_tb.sv

// File: sim/lce_cmd_chk.sv
// lce protocol checker: concurrent assertions on the response and command handshakes
`timescale 1ns/1ps

module lce_cmd_chk
  import lce_pkg::*;
(
  input logic      clk_i,
  input logic      reset_i,
  input lce_resp_s resp_i,
  input logic      resp_v_i,
  input logic      resp_ready_i,
  input logic      cmd_yumi_i,
  input logic      ready_i,
  input logic      req_complete_i
);

  // number of failed assertions
  int fail_cnt = 0;

  // a response is only offered while the directory can take it
  resp_v_needs_ready: assert property (
    @(posedge clk_i) disable iff (reset_i) resp_v_i |-> resp_ready_i
  ) else begin
    fail_cnt++;
    $error("response valid raised without ready");
  end

  cmd_yumi_needs_ready: assert property (
    @(posedge clk_i) disable iff (reset_i) cmd_yumi_i |-> ready_i
  ) else begin
    fail_cnt++;
    $error("command dequeued before the clear finished");
  end

  // the completion pulse marks the coh_ack going out
  complete_with_coh_ack: assert property (
    @(posedge clk_i) disable iff (reset_i)
    req_complete_i |-> (resp_v_i && resp_i.msg_type == e_resp_coh_ack)
  ) else begin
    fail_cnt++;
    $error("request complete without a coh_ack being sent");
  end

endmodule

// File: sim/lce_cmd_tb.sv
// lce command testbench with memory and directory models driving directed tests on the command engine
`timescale 1ns/1ps

module lce_cmd_tb
  import lce_pkg::*;
();

  localparam int NUM_TESTS = 5;

  logic               clk_i;
  logic               reset_i;
  logic [LCE_ID_W-1:0] lce_id;
  lce_cmd_s           cmd;
  logic               cmd_v;
  logic               cmd_yumi;
  lce_resp_s          resp;
  logic               resp_v;
  logic               resp_ready = 1'b0;
  tag_mem_pkt_s       tag_pkt;
  logic               tag_v;
  logic               tag_yumi;
  stat_mem_pkt_s      stat_pkt;
  logic               stat_v;
  logic               stat_yumi;
  data_mem_pkt_s      data_pkt;
  logic               data_v;
  logic               data_yumi;
  stat_info_s         stat_mem = '0;
  logic [BLOCK_W-1:0] data_mem = '0;
  logic               ready;
  logic               sync_done;
  logic               req_complete;

  // memory model contents
  coh_state_e         state_m [SETS][ASSOC];
  logic [TAG_W-1:0]   tag_m   [SETS][ASSOC];
  logic               dirty_m [SETS][ASSOC];
  logic [BLOCK_W-1:0] block_m [SETS][ASSOC];
  stat_info_s         stat_rd_q = '0;
  logic [BLOCK_W-1:0] data_rd_q = '0;

  // random accept pattern for the memories
  integer             seed = 32'h71e326e3;
  logic               tag_go = 1'b0;
  logic               stat_go = 1'b0;
  logic               data_go = 1'b0;

  logic               poke_v;
  logic [LG_SETS-1:0] poke_idx;
  logic [LG_ASSOC-1:0] poke_way;

  lce_resp_s          resp_q[$];
  logic               cplt_q[$];
  logic [LG_SETS-1:0] clear_idx_q[$];
  int                 resp_rd = 0;
  int                 cmd_acc_cnt;
  int                 err_cnt = 0;
  int                 total_err;

  lce_cmd_top lce_cmd_top_i (
    .clk_i                (clk_i),
    .reset_i              (reset_i),
    .lce_id_i             (lce_id),
    .lce_cmd_i            (cmd),
    .lce_cmd_v_i          (cmd_v),
    .lce_cmd_yumi_o       (cmd_yumi),
    .lce_resp_o           (resp),
    .lce_resp_v_o         (resp_v),
    .lce_resp_ready_i     (resp_ready),
    .tag_mem_pkt_o        (tag_pkt),
    .tag_mem_pkt_v_o      (tag_v),
    .tag_mem_pkt_yumi_i   (tag_yumi),
    .stat_mem_pkt_o       (stat_pkt),
    .stat_mem_pkt_v_o     (stat_v),
    .stat_mem_pkt_yumi_i  (stat_yumi),
    .stat_mem_i           (stat_mem),
    .data_mem_pkt_o       (data_pkt),
    .data_mem_pkt_v_o     (data_v),
    .data_mem_pkt_yumi_i  (data_yumi),
    .data_mem_i           (data_mem),
    .ready_o              (ready),
    .sync_done_o          (sync_done),
    .cache_req_complete_o (req_complete)
  );

  bind lce_cmd_top lce_cmd_chk lce_cmd_chk_i (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .resp_i         (lce_resp_o),
    .resp_v_i       (lce_resp_v_o),
    .resp_ready_i   (lce_resp_ready_i),
    .cmd_yumi_i     (lce_cmd_yumi_o),
    .ready_i        (ready_o),
    .req_complete_i (cache_req_complete_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // memories accept in the same cycle whenever their go bit is up
  assign tag_yumi  = tag_v & tag_go;
  assign stat_yumi = stat_v & stat_go;
  assign data_yumi = data_v & data_go;

  always @(negedge clk_i) begin
    tag_go     = ($random(seed) & 3) != 0;
    stat_go    = ($random(seed) & 3) != 0;
    data_go    = ($random(seed) & 3) != 0;
    resp_ready = ($random(seed) & 3) != 0;
    // read results show up the cycle after the yumi
    stat_mem   = stat_rd_q;
    data_mem   = data_rd_q;
  end

  // memory model and response monitor
  always @(posedge clk_i) begin
    if (reset_i) begin
      cmd_acc_cnt <= 0;
      for (int s = 0; s < SETS; s++) begin
        for (int w = 0; w < ASSOC; w++) begin
          state_m[s][w] <= e_coh_e;
          tag_m[s][w]   <= TAG_W'(s * ASSOC + w);
          dirty_m[s][w] <= 1'b1;
          block_m[s][w] <= {32'(s), 32'(w)} ^ 64'h5a5a_0000_a5a5_0000;
        end
      end
    end else begin
      if (tag_v && tag_yumi) begin
        case (tag_pkt.opcode)
          e_tag_set_clear: begin
            for (int w = 0; w < ASSOC; w++) begin
              state_m[tag_pkt.index][w] <= e_coh_i;
              tag_m[tag_pkt.index][w]   <= '0;
            end
          end
          e_tag_set_state: state_m[tag_pkt.index][tag_pkt.way_id] <= tag_pkt.state;
          default: begin
            state_m[tag_pkt.index][tag_pkt.way_id] <= tag_pkt.state;
            tag_m[tag_pkt.index][tag_pkt.way_id]   <= tag_pkt.tag;
          end
        endcase
      end
      if (stat_v && stat_yumi) begin
        for (int w = 0; w < ASSOC; w++) begin
          if (stat_pkt.opcode == e_stat_set_clear) begin
            dirty_m[stat_pkt.index][w] <= 1'b0;
          end
          stat_rd_q.dirty[w] <= dirty_m[stat_pkt.index][w];
        end
        if (stat_pkt.opcode == e_stat_clear_dirty) begin
          dirty_m[stat_pkt.index][stat_pkt.way_id] <= 1'b0;
        end
      end
      if (data_v && data_yumi) begin
        if (data_pkt.opcode == e_data_write) begin
          block_m[data_pkt.index][data_pkt.way_id] <= data_pkt.data;
        end
        data_rd_q <= block_m[data_pkt.index][data_pkt.way_id];
      end
      if (poke_v) begin
        dirty_m[poke_idx][poke_way] <= 1'b1;
      end
      // clear pairs count only when both memories take them together
      if (!ready && tag_v && tag_yumi && stat_v && stat_yumi) begin
        clear_idx_q.push_back(tag_pkt.index);
      end
      if (resp_v) begin
        resp_q.push_back(resp);
        cplt_q.push_back(req_complete);
      end
      if (cmd_yumi) begin
        cmd_acc_cnt <= cmd_acc_cnt + 1;
      end
    end
  end

  task automatic compare_value(input logic [BLOCK_W-1:0] got, input logic [BLOCK_W-1:0] exp,
                               input string what);
    if (got !== exp) begin
      err_cnt++;
      $display("[ERROR] %0t ns: %s got %0h expected %0h", $time, what, got, exp);
    end
  endtask

  function automatic logic [PADDR_W-1:0] make_addr(input logic [TAG_W-1:0] tg,
                                                   input logic [LG_SETS-1:0] ix);
    return {tg, ix, OFFSET_W'(0)};
  endfunction

  // holds the command until the DUT dequeues it
  task automatic send_cmd(input cmd_type_e t, input logic [PADDR_W-1:0] a,
                          input logic [CCE_ID_W-1:0] src, input logic [LG_ASSOC-1:0] way,
                          input coh_state_e st, input logic [BLOCK_W-1:0] d);
    int start;
    start        = cmd_acc_cnt;
    cmd.msg_type = t;
    cmd.addr     = a;
    cmd.src_id   = src;
    cmd.way_id   = way;
    cmd.state    = st;
    cmd.data     = d;
    cmd_v        = 1'b1;
    while (cmd_acc_cnt == start) begin
      @(negedge clk_i);
    end
    cmd_v = 1'b0;
  endtask

  task automatic expect_resp(input resp_type_e t, input logic [PADDR_W-1:0] a,
                             input logic [CCE_ID_W-1:0] dst, input logic [BLOCK_W-1:0] d);
    lce_resp_s got;
    if (resp_rd >= resp_q.size()) begin
      err_cnt++;
      $display("%0t ns: expected a %s response but none was sent", $time, t.name());
    end else begin
      got = resp_q[resp_rd];
      compare_value(BLOCK_W'(got.msg_type), BLOCK_W'(t), "response type");
      compare_value(BLOCK_W'(got.addr), BLOCK_W'(a), "response addr");
      compare_value(BLOCK_W'(got.src_id), BLOCK_W'(lce_id), "response src_id");
      compare_value(BLOCK_W'(got.dst_id), BLOCK_W'(dst), "response dst_id");
      compare_value(got.data, d, "response data");
      compare_value(BLOCK_W'(cplt_q[resp_rd]), BLOCK_W'(t == e_resp_coh_ack), "req complete");
      resp_rd++;
    end
  endtask

  task automatic expect_no_resp(input string what);
    compare_value(BLOCK_W'(resp_q.size()), BLOCK_W'(resp_rd), what);
  endtask

  task automatic mark_dirty(input logic [LG_SETS-1:0] idx, input logic [LG_ASSOC-1:0] way);
    poke_idx = idx;
    poke_way = way;
    poke_v   = 1'b1;
    @(negedge clk_i);
    poke_v   = 1'b0;
  endtask

  task automatic clear_sweep();
    // the first directory sync is already waiting while the sets are cleared
    cmd          = '0;
    cmd.msg_type = e_cmd_sync;
    cmd.addr     = make_addr(TAG_W'(0), '0);
    cmd_v        = 1'b1;
    while (!ready) begin
      @(negedge clk_i);
    end
    compare_value(BLOCK_W'(clear_idx_q.size()), BLOCK_W'(SETS), "clear pair count");
    for (int i = 0; i < clear_idx_q.size() && i < SETS; i++) begin
      compare_value(BLOCK_W'(clear_idx_q[i]), BLOCK_W'(i), "clear index");
    end
    for (int s = 0; s < SETS; s++) begin
      for (int w = 0; w < ASSOC; w++) begin
        compare_value(BLOCK_W'(state_m[s][w]), BLOCK_W'(e_coh_i), "state after clear");
        compare_value(BLOCK_W'(dirty_m[s][w]), '0, "dirty after clear");
      end
    end
  endtask

  task automatic sync_acks();
    for (int c = 0; c < NUM_CCE; c++) begin
      send_cmd(e_cmd_sync, make_addr(TAG_W'(c), '0), CCE_ID_W'(c), '0, e_coh_i, '0);
      expect_resp(e_resp_sync_ack, make_addr(TAG_W'(c), '0), CCE_ID_W'(c), '0);
      compare_value(BLOCK_W'(sync_done), BLOCK_W'(c == NUM_CCE - 1), "sync done");
    end
  endtask

  task automatic state_ops();
    logic [PADDR_W-1:0] a;
    a = make_addr(TAG_W'('h155), LG_SETS'(5));
    send_cmd(e_cmd_st, a, 1'b0, 1'b1, e_coh_m, '0);
    compare_value(BLOCK_W'(state_m[5][1]), BLOCK_W'(e_coh_m), "st state");
    expect_no_resp("st response count");
    send_cmd(e_cmd_inv, a, 1'b1, 1'b1, e_coh_m, '0);
    expect_resp(e_resp_inv_ack, a, 1'b1, '0);
    compare_value(BLOCK_W'(state_m[5][1]), BLOCK_W'(e_coh_i), "inv state");
    send_cmd(e_cmd_st, a, 1'b0, 1'b0, e_coh_s, '0);
    send_cmd(e_cmd_st, a, 1'b0, 1'b1, e_coh_e, '0);
    send_cmd(e_cmd_set_clear, a, 1'b1, 1'b0, e_coh_m, '0);
    compare_value(BLOCK_W'(state_m[5][0]), BLOCK_W'(e_coh_i), "set clear way 0");
    compare_value(BLOCK_W'(state_m[5][1]), BLOCK_W'(e_coh_i), "set clear way 1");
    expect_no_resp("set clear response count");
  endtask

  task automatic fill_and_wakeup();
    logic [PADDR_W-1:0] a;
    logic [PADDR_W-1:0] b;
    logic [BLOCK_W-1:0] d;
    a = make_addr(TAG_W'('h2b7), LG_SETS'(3));
    b = make_addr(TAG_W'('h0c4), LG_SETS'(3));
    d = 64'h0123_4567_89ab_cdef;
    send_cmd(e_cmd_data, a, 1'b1, 1'b0, e_coh_e, d);
    expect_resp(e_resp_coh_ack, a, 1'b1, '0);
    compare_value(block_m[3][0], d, "fill block");
    compare_value(BLOCK_W'(tag_m[3][0]), BLOCK_W'('h2b7), "fill tag");
    compare_value(BLOCK_W'(state_m[3][0]), BLOCK_W'(e_coh_e), "fill state");
    // wakeup changes only the state
    send_cmd(e_cmd_st_wakeup, b, 1'b0, 1'b0, e_coh_s, 64'hffff_0000_ffff_0000);
    expect_resp(e_resp_coh_ack, b, 1'b0, '0);
    compare_value(BLOCK_W'(state_m[3][0]), BLOCK_W'(e_coh_s), "wakeup state");
    compare_value(BLOCK_W'(tag_m[3][0]), BLOCK_W'('h2b7), "wakeup tag");
    compare_value(block_m[3][0], d, "wakeup block");
  endtask

  task automatic writeback_lines();
    logic [PADDR_W-1:0] a;
    a = make_addr(TAG_W'('h2b7), LG_SETS'(3));
    send_cmd(e_cmd_wb, a, 1'b1, 1'b0, e_coh_s, '0);
    expect_resp(e_resp_null_wb, a, 1'b1, '0);
    mark_dirty(LG_SETS'(3), 1'b0);
    send_cmd(e_cmd_wb, a, 1'b0, 1'b0, e_coh_s, '0);
    expect_resp(e_resp_wb, a, 1'b0, block_m[3][0]);
    compare_value(BLOCK_W'(dirty_m[3][0]), '0, "dirty after writeback");
    expect_no_resp("total response count");
  endtask

  initial begin
    reset_i  = 1'b1;
    cmd      = '0;
    cmd_v    = 1'b0;
    lce_id   = 2'd2;
    poke_v   = 1'b0;
    poke_idx = '0;
    poke_way = '0;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    clear_sweep();
    sync_acks();
    state_ops();
    fill_and_wakeup();
    writeback_lines();
    total_err = err_cnt + lce_cmd_top_i.lce_cmd_chk_i.fail_cnt;
    $display("errors: %0d check, %0d assertion", err_cnt, lce_cmd_top_i.lce_cmd_chk_i.fail_cnt);
    if (total_err == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(NUM_TESTS * 2000);
    $display("timeout: the tests did not finish within %0d ns", NUM_TESTS * 2000);
    $display("Test FAILED");
    $finish;
  end

endmodule

// File: source/lce_cmd_fsm.sv
// lce command FSM: clears the cache, decodes directory commands into memory packets and responses
`timescale 1ns/1ps

module lce_cmd_fsm
  import lce_pkg::*;
(
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic [LCE_ID_W-1:0] lce_id_i,
  input  lce_cmd_s            cmd_i,
  input  logic                cmd_v_i,
  output logic                cmd_yumi_o,
  output lce_resp_s           resp_o,
  output logic                resp_v_o,
  input  logic                resp_ready_i,
  output tag_mem_pkt_s        tag_pkt_o,
  output logic                tag_pkt_v_o,
  input  logic                tag_pkt_yumi_i,
  output stat_mem_pkt_s       stat_pkt_o,
  output logic                stat_pkt_v_o,
  input  logic                stat_pkt_yumi_i,
  output data_mem_pkt_s       data_pkt_o,
  output logic                data_pkt_v_o,
  input  logic                data_pkt_yumi_i,
  input  logic [BLOCK_W-1:0]  data_buf_i,
  input  logic                data_buf_v_i,
  input  stat_info_s          stat_buf_i,
  input  logic                stat_buf_v_i,
  output logic                ready_o,
  output logic                sync_done_o,
  output logic                cache_req_complete_o
);

  typedef enum logic [2:0] {
    e_reset, e_clear, e_ready, e_coh_ack, e_wb, e_wb_dirty_rd, e_wb_dirty_send
  } fsm_state_e;

  fsm_state_e          state_r;
  fsm_state_e          state_n;
  logic [CNT_W-1:0]    cnt_r;
  logic                cnt_inc;
  logic                cnt_clr;
  logic                sync_done_en;
  logic                sync_done_li;
  logic [LG_SETS-1:0]  cmd_index;
  logic [TAG_W-1:0]    cmd_tag;
  logic                both_yumi;

  // address split used by every packet built from a command
  assign cmd_index = cmd_i.addr[OFFSET_W +: LG_SETS];
  assign cmd_tag   = cmd_i.addr[PADDR_W-1 -: TAG_W];

  // tag and status writes that travel as a pair advance together
  assign both_yumi = tag_pkt_yumi_i & stat_pkt_yumi_i;

  assign ready_o = (state_r != e_reset) && (state_r != e_clear);

  always_comb begin
    state_n              = state_r;
    cmd_yumi_o           = 1'b0;
    resp_v_o             = 1'b0;
    tag_pkt_v_o          = 1'b0;
    stat_pkt_v_o         = 1'b0;
    data_pkt_v_o         = 1'b0;
    cache_req_complete_o = 1'b0;
    cnt_inc              = 1'b0;
    cnt_clr              = 1'b0;
    sync_done_en         = 1'b0;
    sync_done_li         = 1'b0;

    // every response is addressed back to the CCE that sent the command
    resp_o          = '0;
    resp_o.addr     = cmd_i.addr;
    resp_o.src_id   = lce_id_i;
    resp_o.dst_id   = cmd_i.src_id;

    tag_pkt_o        = '0;
    tag_pkt_o.index  = cmd_index;
    tag_pkt_o.way_id = cmd_i.way_id;
    tag_pkt_o.state  = cmd_i.state;

    stat_pkt_o        = '0;
    stat_pkt_o.index  = cmd_index;
    stat_pkt_o.way_id = cmd_i.way_id;

    data_pkt_o        = '0;
    data_pkt_o.index  = cmd_index;
    data_pkt_o.way_id = cmd_i.way_id;

    case (state_r)
      e_reset: begin
        sync_done_en = 1'b1;
        state_n      = e_clear;
      end

      // walk every set, clearing tags and status bits
      e_clear: begin
        tag_pkt_o.opcode  = e_tag_set_clear;
        tag_pkt_o.index   = cnt_r[LG_SETS-1:0];
        tag_pkt_o.way_id  = '0;
        tag_pkt_o.state   = e_coh_i;
        tag_pkt_v_o       = 1'b1;
        stat_pkt_o.opcode = e_stat_set_clear;
        stat_pkt_o.index  = cnt_r[LG_SETS-1:0];
        stat_pkt_o.way_id = '0;
        stat_pkt_v_o      = 1'b1;
        if (both_yumi) begin
          if (cnt_r == CNT_W'(SETS-1)) begin
            cnt_clr = 1'b1;
            state_n = e_ready;
          end else begin
            cnt_inc = 1'b1;
          end
        end
      end

      e_ready: begin
        if (cmd_v_i) begin
          case (cmd_i.msg_type)
            e_cmd_sync: begin
              resp_o.msg_type = e_resp_sync_ack;
              resp_v_o        = resp_ready_i;
              cmd_yumi_o      = resp_v_o;
              // last ack from all directories finishes the sync
              if (resp_v_o && cnt_r == CNT_W'(NUM_CCE-1)) begin
                cnt_clr      = 1'b1;
                sync_done_en = 1'b1;
                sync_done_li = 1'b1;
              end else begin
                cnt_inc = resp_v_o;
              end
            end

            e_cmd_set_clear: begin
              tag_pkt_o.opcode  = e_tag_set_clear;
              tag_pkt_v_o       = 1'b1;
              stat_pkt_o.opcode = e_stat_set_clear;
              stat_pkt_v_o      = 1'b1;
              cmd_yumi_o        = both_yumi;
            end

            e_cmd_inv: begin
              tag_pkt_o.opcode = e_tag_set_state;
              tag_pkt_o.state  = e_coh_i;
              tag_pkt_v_o      = 1'b1;
              resp_o.msg_type  = e_resp_inv_ack;
              resp_v_o         = tag_pkt_yumi_i & resp_ready_i;
              cmd_yumi_o       = resp_v_o;
            end

            e_cmd_st: begin
              tag_pkt_o.opcode = e_tag_set_state;
              tag_pkt_v_o      = 1'b1;
              cmd_yumi_o       = tag_pkt_yumi_i;
            end

            // fill: write block and tag, then ack in e_coh_ack
            e_cmd_data: begin
              data_pkt_o.opcode = e_data_write;
              data_pkt_o.data   = cmd_i.data;
              data_pkt_v_o      = 1'b1;
              tag_pkt_o.opcode  = e_tag_set_tag;
              tag_pkt_o.tag     = cmd_tag;
              tag_pkt_v_o       = 1'b1;
              if (tag_pkt_yumi_i && data_pkt_yumi_i) begin
                state_n = e_coh_ack;
              end
            end

            e_cmd_st_wakeup: begin
              tag_pkt_o.opcode = e_tag_set_state;
              tag_pkt_v_o      = 1'b1;
              if (tag_pkt_yumi_i) begin
                state_n = e_coh_ack;
              end
            end

            // look up the dirty bit first
            e_cmd_wb: begin
              stat_pkt_o.opcode = e_stat_read;
              stat_pkt_v_o      = 1'b1;
              if (stat_pkt_yumi_i) begin
                state_n = e_wb;
              end
            end

            default: begin
              state_n = e_ready;
            end
          endcase
        end
      end

      e_coh_ack: begin
        resp_o.msg_type      = e_resp_coh_ack;
        resp_v_o             = cmd_v_i & resp_ready_i;
        cmd_yumi_o           = resp_v_o;
        cache_req_complete_o = resp_v_o;
        if (resp_v_o) begin
          state_n = e_ready;
        end
      end

      // clean line gets a null writeback, dirty line is read out
      e_wb: begin
        resp_o.msg_type = e_resp_null_wb;
        resp_v_o   = resp_ready_i & stat_buf_v_i & ~stat_buf_i.dirty[cmd_i.way_id];
        cmd_yumi_o = resp_v_o;
        if (stat_buf_v_i && stat_buf_i.dirty[cmd_i.way_id]) begin
          state_n = e_wb_dirty_rd;
        end else if (resp_v_o) begin
          state_n = e_ready;
        end
      end

      e_wb_dirty_rd: begin
        data_pkt_o.opcode = e_data_read;
        data_pkt_v_o      = 1'b1;
        stat_pkt_o.opcode = e_stat_clear_dirty;
        stat_pkt_v_o      = 1'b1;
        if (data_pkt_yumi_i && stat_pkt_yumi_i) begin
          state_n = e_wb_dirty_send;
        end
      end

      e_wb_dirty_send: begin
        resp_o.msg_type = e_resp_wb;
        resp_o.data     = data_buf_i;
        resp_v_o        = resp_ready_i & data_buf_v_i;
        cmd_yumi_o      = resp_v_o;
        if (resp_v_o) begin
          state_n = e_ready;
        end
      end

      default: begin
        state_n = e_reset;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r     <= e_reset;
      cnt_r       <= '0;
      sync_done_o <= 1'b0;
    end else begin
      state_r <= state_n;
      if (cnt_clr) begin
        cnt_r <= '0;
      end else if (cnt_inc) begin
        cnt_r <= cnt_r + CNT_W'(1);
      end
      if (sync_done_en) begin
        sync_done_o <= sync_done_li;
      end
    end
  end

endmodule

// File: source/lce_cmd_top.sv
// lce command top: joins the command FSM and the memory read buffer
`timescale 1ns/1ps

module lce_cmd_top
  import lce_pkg::*;
(
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic [LCE_ID_W-1:0] lce_id_i,
  input  lce_cmd_s            lce_cmd_i,
  input  logic                lce_cmd_v_i,
  output logic                lce_cmd_yumi_o,
  output lce_resp_s           lce_resp_o,
  output logic                lce_resp_v_o,
  input  logic                lce_resp_ready_i,
  output tag_mem_pkt_s        tag_mem_pkt_o,
  output logic                tag_mem_pkt_v_o,
  input  logic                tag_mem_pkt_yumi_i,
  output stat_mem_pkt_s       stat_mem_pkt_o,
  output logic                stat_mem_pkt_v_o,
  input  logic                stat_mem_pkt_yumi_i,
  input  stat_info_s          stat_mem_i,
  output data_mem_pkt_s       data_mem_pkt_o,
  output logic                data_mem_pkt_v_o,
  input  logic                data_mem_pkt_yumi_i,
  input  logic [BLOCK_W-1:0]  data_mem_i,
  output logic                ready_o,
  output logic                sync_done_o,
  output logic                cache_req_complete_o
);

  logic [BLOCK_W-1:0] data_buf;
  logic               data_buf_v;
  stat_info_s         stat_buf;
  logic               stat_buf_v;

  lce_cmd_fsm lce_cmd_fsm_i (
    .clk_i                (clk_i),
    .reset_i              (reset_i),
    .lce_id_i             (lce_id_i),
    .cmd_i                (lce_cmd_i),
    .cmd_v_i              (lce_cmd_v_i),
    .cmd_yumi_o           (lce_cmd_yumi_o),
    .resp_o               (lce_resp_o),
    .resp_v_o             (lce_resp_v_o),
    .resp_ready_i         (lce_resp_ready_i),
    .tag_pkt_o            (tag_mem_pkt_o),
    .tag_pkt_v_o          (tag_mem_pkt_v_o),
    .tag_pkt_yumi_i       (tag_mem_pkt_yumi_i),
    .stat_pkt_o           (stat_mem_pkt_o),
    .stat_pkt_v_o         (stat_mem_pkt_v_o),
    .stat_pkt_yumi_i      (stat_mem_pkt_yumi_i),
    .data_pkt_o           (data_mem_pkt_o),
    .data_pkt_v_o         (data_mem_pkt_v_o),
    .data_pkt_yumi_i      (data_mem_pkt_yumi_i),
    .data_buf_i           (data_buf),
    .data_buf_v_i         (data_buf_v),
    .stat_buf_i           (stat_buf),
    .stat_buf_v_i         (stat_buf_v),
    .ready_o              (ready_o),
    .sync_done_o          (sync_done_o),
    .cache_req_complete_o (cache_req_complete_o)
  );

  // watches the same packets the FSM sends to catch read results
  lce_read_buf lce_read_buf_i (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .data_pkt_i      (data_mem_pkt_o),
    .data_pkt_v_i    (data_mem_pkt_v_o),
    .data_pkt_yumi_i (data_mem_pkt_yumi_i),
    .stat_pkt_i      (stat_mem_pkt_o),
    .stat_pkt_v_i    (stat_mem_pkt_v_o),
    .stat_pkt_yumi_i (stat_mem_pkt_yumi_i),
    .data_mem_i      (data_mem_i),
    .stat_mem_i      (stat_mem_i),
    .data_buf_o      (data_buf),
    .data_buf_v_o    (data_buf_v),
    .stat_buf_o      (stat_buf),
    .stat_buf_v_o    (stat_buf_v)
  );

endmodule

// File: source/lce_pkg.sv
// lce package: sizes, coherence encodings and packet formats for the command engine
package lce_pkg;

  // cache geometry
  localparam int SETS      = 8;
  localparam int ASSOC     = 2;
  localparam int LG_SETS   = 3;
  localparam int LG_ASSOC  = 1;
  localparam int BLOCK_W   = 64;
  localparam int OFFSET_W  = 3;
  localparam int PADDR_W   = 16;
  localparam int TAG_W     = PADDR_W - LG_SETS - OFFSET_W;

  // system ids
  localparam int LCE_ID_W  = 2;
  localparam int CCE_ID_W  = 1;
  localparam int NUM_CCE   = 2;

  // shared set walk and sync ack counter
  localparam int CNT_W     = 4;

  typedef enum logic [1:0] {e_coh_i, e_coh_s, e_coh_e, e_coh_m} coh_state_e;

  typedef enum logic [2:0] {
    e_cmd_sync, e_cmd_set_clear, e_cmd_inv, e_cmd_st,
    e_cmd_data, e_cmd_st_wakeup, e_cmd_wb
  } cmd_type_e;

  typedef enum logic [2:0] {
    e_resp_sync_ack, e_resp_inv_ack, e_resp_coh_ack, e_resp_null_wb, e_resp_wb
  } resp_type_e;

  typedef enum logic [1:0] {e_tag_set_clear, e_tag_set_state, e_tag_set_tag} tag_op_e;
  typedef enum logic [1:0] {e_stat_set_clear, e_stat_read, e_stat_clear_dirty} stat_op_e;
  typedef enum logic {e_data_write, e_data_read} data_op_e;

  // command from the directory, one full block of data rides along
  typedef struct packed {
    cmd_type_e             msg_type;
    logic [PADDR_W-1:0]    addr;
    logic [CCE_ID_W-1:0]   src_id;
    logic [LG_ASSOC-1:0]   way_id;
    coh_state_e            state;
    logic [BLOCK_W-1:0]    data;
  } lce_cmd_s;

  // response back to the directory
  typedef struct packed {
    resp_type_e            msg_type;
    logic [PADDR_W-1:0]    addr;
    logic [LCE_ID_W-1:0]   src_id;
    logic [CCE_ID_W-1:0]   dst_id;
    logic [BLOCK_W-1:0]    data;
  } lce_resp_s;

  typedef struct packed {
    tag_op_e               opcode;
    logic [LG_SETS-1:0]    index;
    logic [LG_ASSOC-1:0]   way_id;
    coh_state_e            state;
    logic [TAG_W-1:0]      tag;
  } tag_mem_pkt_s;

  typedef struct packed {
    stat_op_e              opcode;
    logic [LG_SETS-1:0]    index;
    logic [LG_ASSOC-1:0]   way_id;
  } stat_mem_pkt_s;

  typedef struct packed {
    data_op_e              opcode;
    logic [LG_SETS-1:0]    index;
    logic [LG_ASSOC-1:0]   way_id;
    logic [BLOCK_W-1:0]    data;
  } data_mem_pkt_s;

  // status read result, one dirty bit per way
  typedef struct packed {
    logic [ASSOC-1:0]      dirty;
  } stat_info_s;

endpackage

// File: source/lce_read_buf.sv
// lce read buffer: holds data and status memory read results with valid flags
`timescale 1ns/1ps

module lce_read_buf
  import lce_pkg::*;
(
  input  logic               clk_i,
  input  logic               reset_i,
  input  data_mem_pkt_s      data_pkt_i,
  input  logic               data_pkt_v_i,
  input  logic               data_pkt_yumi_i,
  input  stat_mem_pkt_s      stat_pkt_i,
  input  logic               stat_pkt_v_i,
  input  logic               stat_pkt_yumi_i,
  input  logic [BLOCK_W-1:0] data_mem_i,
  input  stat_info_s         stat_mem_i,
  output logic [BLOCK_W-1:0] data_buf_o,
  output logic               data_buf_v_o,
  output stat_info_s         stat_buf_o,
  output logic               stat_buf_v_o
);

  logic data_rd_acc;
  logic stat_rd_acc;
  logic data_cap_r;
  logic stat_cap_r;

  // a read is taken by the memory when valid and yumi meet on a read opcode
  assign data_rd_acc = data_pkt_v_i & data_pkt_yumi_i & (data_pkt_i.opcode == e_data_read);
  assign stat_rd_acc = stat_pkt_v_i & stat_pkt_yumi_i & (stat_pkt_i.opcode == e_stat_read);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      data_cap_r   <= 1'b0;
      stat_cap_r   <= 1'b0;
      data_buf_v_o <= 1'b0;
      stat_buf_v_o <= 1'b0;
    end else begin
      data_cap_r   <= data_rd_acc;
      stat_cap_r   <= stat_rd_acc;
      // a fresh read drops the old result until its own data arrives
      data_buf_v_o <= ~data_rd_acc & (data_buf_v_o | data_cap_r);
      stat_buf_v_o <= ~stat_rd_acc & (stat_buf_v_o | stat_cap_r);
    end
  end

  // memory result is on the bus the cycle after yumi
  always_ff @(posedge clk_i) begin
    if (data_cap_r) begin
      data_buf_o <= data_mem_i;
    end
    if (stat_cap_r) begin
      stat_buf_o <= stat_mem_i;
    end
  end

endmodule
